//--- design/icache_cfg_pkg.sv
/* Instruction cache geometry
 * Sizes of the 4-way, 64-set cache and the layout of a fetch address
 */
package icache_cfg_pkg;

    localparam int ICACHE_N_WAY   = 4;    // Ways per set
    localparam int ICACHE_DEPTH   = 64;   // Sets
    localparam int ADDR_WIDTH     = 32;
    localparam int OFFSET_WIDTH   = 4;    // Byte offset in a 16-byte line
    localparam int INDEX_WIDTH    = 6;
    localparam int TAG_WIDTH      = 22;
    localparam int WORD_WIDTH     = 32;
    localparam int LINE_WIDTH     = 128;
    localparam int WORDS_PER_LINE = 4;
    localparam int PLRU_WIDTH     = 3;    // Tree bits per set

    localparam int WSEL_WIDTH = $clog2(WORDS_PER_LINE);  // Word within line
    localparam int BYTE_WIDTH = OFFSET_WIDTH - WSEL_WIDTH;

    // Field view of a fetch address, MSB first
    typedef struct packed {
        logic [TAG_WIDTH-1:0]   tag;
        logic [INDEX_WIDTH-1:0] index;
        logic [WSEL_WIDTH-1:0]  word_sel;
        logic [BYTE_WIDTH-1:0]  byte_off;   // Always zero for aligned fetch
    } icache_addr_t;

    // Same 32 bits, seen raw by the miss path or split by the arrays
    typedef union packed {
        logic [ADDR_WIDTH-1:0] raw;
        icache_addr_t          fields;
    } icache_addr_u;

endpackage

//--- design/icache_bus_pkg.sv
/* Instruction cache traffic
 * Structs for fetch, response, miss, refill and the array lookup bundle
 */
package icache_bus_pkg;

    // Fetch request from the core
    typedef struct packed {
        logic                       valid;
        icache_cfg_pkg::icache_addr_u addr;
    } fetch_req_t;

    // One-cycle instruction response
    typedef struct packed {
        logic                                  valid;
        logic [icache_cfg_pkg::WORD_WIDTH-1:0] instr;
    } fetch_rsp_t;

    // Line request to next level, offset bits zero
    typedef struct packed {
        logic                                  valid;
        logic [icache_cfg_pkg::ADDR_WIDTH-1:0] line_addr;
    } miss_req_t;

    // Refill strobe with the whole line
    typedef struct packed {
        logic                                  valid;
        logic [icache_cfg_pkg::LINE_WIDTH-1:0] line;
    } refill_t;

    // Registered read of every way, tags, valid bits and lines
    typedef struct packed {
        logic [icache_cfg_pkg::ICACHE_N_WAY-1:0][icache_cfg_pkg::TAG_WIDTH-1:0]  tags;
        logic [icache_cfg_pkg::ICACHE_N_WAY-1:0]                                vbit;
        logic [icache_cfg_pkg::ICACHE_N_WAY-1:0][icache_cfg_pkg::LINE_WIDTH-1:0] lines;
    } lookup_t;

endpackage

//--- design/icache_tag_memory.sv
/* Tag memory
 * Per-way tag arrays and valid bits, masked writes, single-cycle flush
 */
`timescale 1ns/1ns

module icache_tag_memory (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    input  logic                                   rd_i,      // Read all ways
    input  logic                                   we_i,      // Write masked way
    input  logic [icache_cfg_pkg::ICACHE_N_WAY-1:0] way_i,     // One-hot write way
    input  logic                                   flush_i,
    input  icache_cfg_pkg::icache_addr_u           addr_i,
    input  logic [icache_cfg_pkg::TAG_WIDTH-1:0]   tag_i,
    output logic [icache_cfg_pkg::ICACHE_N_WAY-1:0][icache_cfg_pkg::TAG_WIDTH-1:0] tag_way_o,
    output logic [icache_cfg_pkg::ICACHE_N_WAY-1:0] vbit_o
);

    // Tag storage per way and set
    logic [icache_cfg_pkg::TAG_WIDTH-1:0] tag_mem
        [icache_cfg_pkg::ICACHE_N_WAY][icache_cfg_pkg::ICACHE_DEPTH];

    // One valid bit per way and set
    logic [icache_cfg_pkg::ICACHE_N_WAY-1:0][icache_cfg_pkg::ICACHE_DEPTH-1:0] vbit_q;

    logic [icache_cfg_pkg::INDEX_WIDTH-1:0] idx;

    assign idx = addr_i.fields.index;  // Set select

    // Tag write and registered read
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < icache_cfg_pkg::ICACHE_N_WAY; w++) begin
            if (we_i && way_i[w]) begin
                tag_mem[w][idx] <= tag_i;  // Only the masked way
            end
            if (rd_i) begin
                tag_way_o[w] <= tag_mem[w][idx];
            end
        end
    end

    // Valid bits cleared together on reset or flush
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            vbit_q <= '0;
            vbit_o <= '0;
        end else begin
            for (int w = 0; w < icache_cfg_pkg::ICACHE_N_WAY; w++) begin
                if (we_i && way_i[w]) begin
                    vbit_q[w][idx] <= 1'b1;  // Line now present
                end
                if (rd_i) begin
                    vbit_o[w] <= vbit_q[w][idx];
                end
            end
        end
    end

    // A refill lands in exactly one way
    a_we_onehot: assert property (
        @(posedge clk_i) disable iff (rst_i)
        we_i |-> $onehot(way_i)
    ) else $error("tag write with way mask %b", way_i);

endmodule

//--- design/icache_data_memory.sv
/* Data memory
 * Per-way line arrays, masked refill write and registered read of all ways
 */
`timescale 1ns/1ns

module icache_data_memory (
    input  logic                                    clk_i,
    input  logic                                    rd_i,    // Read all ways
    input  logic                                    we_i,    // Refill write
    input  logic [icache_cfg_pkg::ICACHE_N_WAY-1:0] way_i,   // One-hot target way
    input  icache_cfg_pkg::icache_addr_u            addr_i,
    input  logic [icache_cfg_pkg::LINE_WIDTH-1:0]   line_i,
    output logic [icache_cfg_pkg::ICACHE_N_WAY-1:0][icache_cfg_pkg::LINE_WIDTH-1:0] line_way_o
);

    // Behavioral line storage
    logic [icache_cfg_pkg::LINE_WIDTH-1:0] line_mem
        [icache_cfg_pkg::ICACHE_N_WAY][icache_cfg_pkg::ICACHE_DEPTH];

    logic [icache_cfg_pkg::INDEX_WIDTH-1:0] idx;

    assign idx = addr_i.fields.index;

    always_ff @(posedge clk_i) begin
        for (int w = 0; w < icache_cfg_pkg::ICACHE_N_WAY; w++) begin
            if (we_i && way_i[w]) begin
                line_mem[w][idx] <= line_i;  // Whole line at once
            end
            if (rd_i) begin
                line_way_o[w] <= line_mem[w][idx];  // Read before write
            end
        end
    end

endmodule

//--- design/icache_way_select.sv
/* Way select
 * Tag compare over all ways and mux of the addressed word from the hit line
 */
`timescale 1ns/1ns

module icache_way_select (
    input  icache_bus_pkg::lookup_t                 lookup_i,
    input  icache_cfg_pkg::icache_addr_u            addr_q_i,  // Registered fetch address
    output logic                                    hit_o,
    output logic [icache_cfg_pkg::ICACHE_N_WAY-1:0] hit_way_o,
    output logic [icache_cfg_pkg::WORD_WIDTH-1:0]   instr_o
);

    logic [icache_cfg_pkg::ICACHE_N_WAY-1:0] hit_vec;
    logic [icache_cfg_pkg::LINE_WIDTH-1:0]   hit_line;

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < icache_cfg_pkg::ICACHE_N_WAY; w++) begin
            hit_vec[w] = lookup_i.vbit[w] &&
                         (lookup_i.tags[w] == addr_q_i.fields.tag);
            if (hit_vec[w]) begin
                hit_line = hit_line | lookup_i.lines[w];  // AND-OR mux
            end
        end
    end

    assign hit_o     = |hit_vec;
    assign hit_way_o = hit_vec;
    assign instr_o   = hit_line[addr_q_i.fields.word_sel * icache_cfg_pkg::WORD_WIDTH
                                +: icache_cfg_pkg::WORD_WIDTH];

    // Refill never duplicates a line, so two hits mean corrupt arrays
    always_comb begin
        a_single_hit: assert ($onehot0(hit_vec) || $isunknown(hit_vec))
            else $error("multiple ways hit: %b", hit_vec);
    end

endmodule

//--- design/icache_replacement.sv
/* Tree pseudo-LRU replacement
 * Three tree bits per set, victim prefers the lowest invalid way
 */
`timescale 1ns/1ns

module icache_replacement (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    input  logic                                    flush_i,
    input  logic [icache_cfg_pkg::INDEX_WIDTH-1:0]  index_i,
    input  logic [icache_cfg_pkg::ICACHE_N_WAY-1:0] vbit_i,
    input  logic                                    touch_i,      // Hit or refill
    input  logic [icache_cfg_pkg::ICACHE_N_WAY-1:0] touch_way_i,
    output logic [icache_cfg_pkg::ICACHE_N_WAY-1:0] victim_o
);

    // Bit 0 picks the half, bit 1 ways 0/1, bit 2 ways 2/3
    logic [icache_cfg_pkg::PLRU_WIDTH-1:0] plru_q [icache_cfg_pkg::ICACHE_DEPTH];
    logic [icache_cfg_pkg::PLRU_WIDTH-1:0] tree;
    logic [icache_cfg_pkg::PLRU_WIDTH-1:0] tree_upd;

    assign tree = plru_q[index_i];

    // Victim choice
    always_comb begin
        if (!tree[0]) begin
            victim_o = tree[1] ? 4'b0010 : 4'b0001;  // Left half
        end else begin
            victim_o = tree[2] ? 4'b1000 : 4'b0100;  // Right half
        end
        for (int w = icache_cfg_pkg::ICACHE_N_WAY - 1; w >= 0; w--) begin
            if (!vbit_i[w]) begin
                victim_o = '0;
                victim_o[w] = 1'b1;  // Lowest invalid wins
            end
        end
    end

    // Point the tree away from the touched way
    always_comb begin
        tree_upd = tree;
        if (touch_way_i[0] || touch_way_i[1]) begin
            tree_upd[0] = 1'b1;
            tree_upd[1] = touch_way_i[0];
        end else begin
            tree_upd[0] = 1'b0;
            tree_upd[2] = touch_way_i[2];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            for (int s = 0; s < icache_cfg_pkg::ICACHE_DEPTH; s++) begin
                plru_q[s] <= '0;
            end
        end else if (touch_i) begin
            plru_q[index_i] <= tree_upd;
        end
    end

endmodule

//--- design/icache_ctrl.sv
/* Cache controller
 * Sequences lookup, miss request, refill write, response and flush
 */
`timescale 1ns/1ns

module icache_ctrl (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    input  icache_bus_pkg::fetch_req_t              req_i,
    input  icache_bus_pkg::refill_t                 refill_i,
    input  logic                                    flush_i,
    input  logic                                    hit_i,
    input  logic [icache_cfg_pkg::ICACHE_N_WAY-1:0] hit_way_i,
    input  logic [icache_cfg_pkg::WORD_WIDTH-1:0]   instr_i,
    input  logic [icache_cfg_pkg::ICACHE_N_WAY-1:0] victim_i,
    output logic                                    ready_o,
    output icache_bus_pkg::fetch_rsp_t              rsp_o,
    output icache_bus_pkg::miss_req_t               miss_o,
    output logic                                    rd_o,
    output logic                                    we_o,
    output logic [icache_cfg_pkg::ICACHE_N_WAY-1:0] way_o,
    output icache_cfg_pkg::icache_addr_u            addr_o,
    output logic [icache_cfg_pkg::TAG_WIDTH-1:0]    tag_o,
    output logic [icache_cfg_pkg::LINE_WIDTH-1:0]   line_o,
    output logic                                    mem_flush_o,
    output logic                                    touch_o,
    output logic [icache_cfg_pkg::ICACHE_N_WAY-1:0] touch_way_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WAIT,
        ST_WRITE
    } state_e;

    state_e                                  state_q;
    icache_cfg_pkg::icache_addr_u            addr_q;    // Fetch in flight
    logic [icache_cfg_pkg::ICACHE_N_WAY-1:0] victim_q;  // Way chosen at miss
    logic [icache_cfg_pkg::LINE_WIDTH-1:0]   line_q;    // Refill line
    logic                                    accept;
    logic                                    flush_take;
    logic                                    lookup_hit;
    logic                                    lookup_miss;

    assign accept      = (state_q == ST_IDLE) && req_i.valid;
    assign flush_take  = (state_q == ST_IDLE) && flush_i && !req_i.valid;  // Request wins
    assign lookup_hit  = (state_q == ST_LOOKUP) && hit_i;
    assign lookup_miss = (state_q == ST_LOOKUP) && !hit_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE:   if (accept) state_q <= ST_LOOKUP;
                ST_LOOKUP: state_q <= hit_i ? ST_IDLE : ST_WAIT;
                ST_WAIT:   if (refill_i.valid) state_q <= ST_WRITE;
                ST_WRITE:  state_q <= ST_IDLE;
                default:   state_q <= ST_IDLE;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q <= req_i.addr;
        end
        if (lookup_miss) begin
            victim_q <= victim_i;
        end
        if (state_q == ST_WAIT && refill_i.valid) begin
            line_q <= refill_i.line;
        end
    end

    assign ready_o = (state_q == ST_IDLE) && !flush_take;

    // Array control, read address straight from the port when idle
    assign rd_o        = accept;
    assign we_o        = (state_q == ST_WRITE);
    assign way_o       = victim_q;
    assign addr_o      = (state_q == ST_IDLE) ? req_i.addr : addr_q;
    assign tag_o       = addr_q.fields.tag;
    assign line_o      = line_q;
    assign mem_flush_o = flush_take;

    // LRU update on hit or refill write
    assign touch_o     = lookup_hit || we_o;
    assign touch_way_o = we_o ? victim_q : hit_way_i;

    always_comb begin
        rsp_o.valid = lookup_hit || we_o;
        if (we_o) begin
            rsp_o.instr = line_q[addr_q.fields.word_sel * icache_cfg_pkg::WORD_WIDTH
                                 +: icache_cfg_pkg::WORD_WIDTH];  // Word from refill
        end else begin
            rsp_o.instr = instr_i;
        end
        miss_o.valid     = lookup_miss;
        miss_o.line_addr = {addr_q.raw[icache_cfg_pkg::ADDR_WIDTH-1:icache_cfg_pkg::OFFSET_WIDTH],
                            {icache_cfg_pkg::OFFSET_WIDTH{1'b0}}};
    end

    a_rsp_miss_excl: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(rsp_o.valid && miss_o.valid)
    ) else $error("response and miss in the same cycle");

    // Refill only expected while a miss is outstanding
    a_refill_in_wait: assert property (
        @(posedge clk_i) disable iff (rst_i)
        refill_i.valid |-> (state_q == ST_WAIT)
    ) else $error("refill strobe outside wait state");

endmodule

//--- design/icache_top.sv
/* Instruction cache top
 * Connects the controller, tag and data arrays, way select and pseudo-LRU
 */
`timescale 1ns/1ns

module icache_top (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  icache_bus_pkg::fetch_req_t fetch_i,
    output logic                       ready_o,
    output icache_bus_pkg::fetch_rsp_t rsp_o,
    output icache_bus_pkg::miss_req_t  miss_o,
    input  icache_bus_pkg::refill_t    refill_i,
    input  logic                       flush_i
);

    wire icache_bus_pkg::lookup_t            lookup;  // Driven by both arrays
    logic                                    mem_rd;
    logic                                    mem_we;
    logic [icache_cfg_pkg::ICACHE_N_WAY-1:0] mem_way;
    icache_cfg_pkg::icache_addr_u            mem_addr;
    logic [icache_cfg_pkg::TAG_WIDTH-1:0]    mem_tag;
    logic [icache_cfg_pkg::LINE_WIDTH-1:0]   mem_line;
    logic                                    mem_flush;
    logic                                    touch;
    logic [icache_cfg_pkg::ICACHE_N_WAY-1:0] touch_way;
    logic                                    hit;
    logic [icache_cfg_pkg::ICACHE_N_WAY-1:0] hit_way;
    logic [icache_cfg_pkg::WORD_WIDTH-1:0]   hit_instr;
    logic [icache_cfg_pkg::ICACHE_N_WAY-1:0] victim;

    icache_ctrl ctrl_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (fetch_i),
        .refill_i    (refill_i),
        .flush_i     (flush_i),
        .hit_i       (hit),
        .hit_way_i   (hit_way),
        .instr_i     (hit_instr),
        .victim_i    (victim),
        .ready_o     (ready_o),
        .rsp_o       (rsp_o),
        .miss_o      (miss_o),
        .rd_o        (mem_rd),
        .we_o        (mem_we),
        .way_o       (mem_way),
        .addr_o      (mem_addr),
        .tag_o       (mem_tag),
        .line_o      (mem_line),
        .mem_flush_o (mem_flush),
        .touch_o     (touch),
        .touch_way_o (touch_way)
    );

    icache_tag_memory tag_mem_i (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rd_i      (mem_rd),
        .we_i      (mem_we),
        .way_i     (mem_way),
        .flush_i   (mem_flush),
        .addr_i    (mem_addr),
        .tag_i     (mem_tag),
        .tag_way_o (lookup.tags),
        .vbit_o    (lookup.vbit)
    );

    icache_data_memory data_mem_i (
        .clk_i      (clk_i),
        .rd_i       (mem_rd),
        .we_i       (mem_we),
        .way_i      (mem_way),
        .addr_i     (mem_addr),
        .line_i     (mem_line),
        .line_way_o (lookup.lines)
    );

    icache_way_select way_sel_i (
        .lookup_i  (lookup),
        .addr_q_i  (mem_addr),  // Holds the fetch address during lookup
        .hit_o     (hit),
        .hit_way_o (hit_way),
        .instr_o   (hit_instr)
    );

    icache_replacement repl_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .flush_i     (mem_flush),
        .index_i     (mem_addr.fields.index),
        .vbit_i      (lookup.vbit),
        .touch_i     (touch),
        .touch_way_i (touch_way),
        .victim_o    (victim)
    );

endmodule

//--- verif/icache_tb.sv
/* Instruction cache testbench
 * Replays fetch and flush operations from a data file against a refill memory model
 */
`timescale 1ns/1ns

module icache_tb;

    localparam int          MAX_OPS = 64;
    localparam int          TIMEOUT = 40;              // Cycles allowed per wait loop
    localparam logic [31:0] MEM_KEY = 32'h5A5A0000;    // Memory word = byte address ^ key

    logic                       clk_i = 1'b0;
    logic                       rst_i;
    icache_bus_pkg::fetch_req_t fetch_i;
    logic                       ready_o;
    icache_bus_pkg::fetch_rsp_t rsp_o;
    icache_bus_pkg::miss_req_t  miss_o;
    icache_bus_pkg::refill_t    refill_i = '0;
    logic                       flush_i;

    logic [31:0] stim [3*MAX_OPS];   // op, address, expected hit per operation
    integer      seed = 27503;
    int          refill_delay;
    logic [31:0] refill_addr;
    int          checks = 0;
    int          errors = 0;
    bit          stalled = 0;        // Stops the sequence after a timeout

    icache_top dut_i (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .fetch_i  (fetch_i),
        .ready_o  (ready_o),
        .rsp_o    (rsp_o),
        .miss_o   (miss_o),
        .refill_i (refill_i),
        .flush_i  (flush_i)
    );

    always #50 clk_i = ~clk_i;  // 100 ns period

    // Line as next-level memory returns it with word 0 in the low bits
    function automatic logic [127:0] mem_line(input logic [31:0] line_addr);
        logic [127:0] line;
        for (int i = 0; i < 4; i++) begin
            line[i*32 +: 32] = (line_addr + 32'(4 * i)) ^ MEM_KEY;
        end
        return line;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        stalled = 1;
        $display("Timeout: %s within %0d cycles", what, TIMEOUT);
    endtask

    // Poll at the falling edge until the cache can take a request
    task automatic wait_ready(output bit ok);
        int n;
        ok = 0;
        n  = 0;
        while (!ok && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
            ok = ready_o;
        end
    endtask

    // Refill model for one outstanding miss
    always @(negedge clk_i) begin
        if (!rst_i && miss_o.valid) begin
            refill_addr  = miss_o.line_addr;
            refill_delay = 1 + int'($unsigned($random(seed)) % 8);  // 1 to 8 cycles
            repeat (refill_delay) @(posedge clk_i);
            refill_i.valid <= 1'b1;
            refill_i.line  <= mem_line(refill_addr);
            @(posedge clk_i);
            refill_i.valid <= 1'b0;  // Single-cycle strobe
        end
    end

    task automatic run_fetch(input logic [31:0] addr, input logic exp_hit);
        string name;
        bit    ok;
        bit    got_rsp;
        int    cycles;
        int    misses;
        name = $sformatf("fetch %h", addr);
        wait_ready(ok);
        if (!ok) begin
            report_timeout({name, " saw no ready"});
            return;
        end
        @(posedge clk_i);
        fetch_i.valid    <= 1'b1;
        fetch_i.addr.raw <= addr;
        @(posedge clk_i);  // Accepted here since ready was high
        fetch_i.valid <= 1'b0;
        got_rsp = 0;
        cycles  = 0;
        misses  = 0;
        while (!got_rsp && cycles < TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
            if (miss_o.valid) begin
                misses++;
                check_value({name, " miss line"}, {addr[31:4], 4'h0}, miss_o.line_addr);
            end
            check_value({name, " ready low"}, 32'd0, {31'd0, ready_o});  // Busy until rsp
            got_rsp = rsp_o.valid;
        end
        if (!got_rsp) begin
            report_timeout({name, " got no response"});
            return;
        end
        check_value({name, " instr"}, addr ^ MEM_KEY, rsp_o.instr);
        check_value({name, " miss pulses"}, exp_hit ? 32'd0 : 32'd1, 32'(misses));
        if (exp_hit) begin
            check_value({name, " hit latency"}, 32'd1, 32'(cycles));  // Rsp at T+1
        end
        @(negedge clk_i);
        check_value({name, " ready after rsp"}, 32'd1, {31'd0, ready_o});
        check_value({name, " rsp pulse width"}, 32'd0, {31'd0, rsp_o.valid});  // One cycle only
    endtask

    task automatic run_flush();
        bit ok;
        wait_ready(ok);
        if (!ok) begin
            report_timeout("flush saw no ready");
            return;
        end
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(negedge clk_i);
        check_value("flush ready low", 32'd0, {31'd0, ready_o});
        @(posedge clk_i);  // Valid and tree bits clear at this edge
        flush_i <= 1'b0;
    endtask

    initial begin
        int op_idx;
        rst_i   = 1'b1;
        fetch_i = '0;
        flush_i = 1'b0;
        $readmemh("verif/icache_input.txt", stim);
        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_value("reset ready", 32'd1, {31'd0, ready_o});
        check_value("reset rsp valid", 32'd0, {31'd0, rsp_o.valid});
        check_value("reset miss valid", 32'd0, {31'd0, miss_o.valid});
        op_idx = 0;
        while (!stalled && op_idx < MAX_OPS && stim[3*op_idx] != 32'd0) begin
            if (stim[3*op_idx] == 32'd1) begin
                run_fetch(stim[3*op_idx+1], stim[3*op_idx+2][0]);
            end else begin
                run_flush();
            end
            op_idx++;
        end
        $display("Operations: %0d, checks: %0d, errors: %0d", op_idx, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- verif/icache_input.txt
// Columns (hex): op (1 fetch, 2 flush, 0 end), fetch address, expected hit (1) or miss (0)
// Set 5 lines: 2050 2450 2850 2C50 3050, the fifth evicts way 0
1 00001000 0
1 00001004 1
1 0000100C 1
1 00001000 1
1 00002050 0
1 00002450 0
1 00002850 0
1 00002C50 0
1 00003050 0
1 00002454 1
1 00002858 1
1 00002C5C 1
1 00002050 0
1 00003050 0
1 0000ABCC 0
2 00000000 0
1 00001008 0
1 00002858 0
1 0000ABCC 0
1 0000ABC4 1
0 00000000 0

//--- sources.f
design/icache_cfg_pkg.sv
design/icache_bus_pkg.sv
design/icache_tag_memory.sv
design/icache_data_memory.sv
design/icache_way_select.sv
design/icache_replacement.sv
design/icache_ctrl.sv
design/icache_top.sv
verif/icache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the instruction cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module icache_tb -f sources.f \
    -o icache_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/icache_sim > sim.log 2>&1 || echo "Simulator exited with an error"
grep -q ">>> FAIL" sim.log && { echo "Test failed, see sim.log"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "No pass message in sim.log"; exit 1; }
echo "Test passed"
